// File: common/dac_frame_pkg.sv
// serial DAC frame definitions
// sck timing, ldac pulse length and the serializer state encoding

`default_nettype none

package dac_frame_pkg;

  // ========================================
  // frame timing
  // ========================================

  // clk cycles per sck half period
  localparam int SCK_HALF = 2;  // sck at clk/4

  // ldac_n low time after the frame
  localparam int LDAC_CYCLES = 2;

  // bit counter and timing counter width
  // big enough for a 20 bit word
  localparam int BIT_CNT_W = 5;

  // ========================================
  // serializer states
  // ========================================

  typedef enum logic [2:0] {
    ST_IDLE,   // wait for trigger edge
    ST_LOAD,   // pop head word into shifter
    ST_SHIFT,  // sync_n low, bits on sdi/sck
    ST_GAP,    // sync_n back high
    ST_LDAC    // ldac_n strobe
  } dac_state_t;

  // ST_LOAD and ST_GAP last one cycle each
  // ST_SHIFT runs 2*SCK_HALF cycles per bit

endpackage : dac_frame_pkg

`default_nettype wire

// File: common/stream_pkg.sv
// host datapath definitions
// word format and FIFO geometry shared by the intake, the FIFO and the
// serializer

`default_nettype none

package stream_pkg;

  // ========================================
  // word format
  // ========================================

  // one DAC word as written by the host
  localparam int WORD_W = 20;

  typedef logic [WORD_W-1:0] word_t;  // payload as it sits in the FIFO

  // ========================================
  // FIFO geometry
  // ========================================

  // power of two so the pointers wrap on their own
  localparam int FIFO_DEPTH = 16;

  localparam int PTR_W = $clog2(FIFO_DEPTH);  // 4 bits for 16 entries

  // occupancy needs one more bit than the pointers
  // so that full and empty stay distinct
  // the FIFO builds that count from PTR_W

endpackage : stream_pkg

`default_nettype wire

// File: dac/dac_serializer.sv
// DAC frame serializer
// synchronizes the trigger and pops one word per rising edge
// shifts the word MSB first on sdi/sck inside a sync_n low window
// then strobes ldac_n. a trigger with nothing stored sets underrun

`default_nettype none

module dac_serializer (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               trigger,
  input  stream_pkg::word_t  fifo_rdata,
  input  wire               fifo_empty,
  output logic              fifo_rd,
  output logic              sync_n,
  output logic              sck,
  output logic              sdi,
  output logic              ldac_n,
  output logic              underrun
);

  import stream_pkg::*;
  import dac_frame_pkg::*;

  dac_state_t state;

  logic                 trig_s1;
  logic                 trig_s2;   // synchronized trigger
  logic                 trig_d;    // delayed copy for edge detect
  logic                 trig_edge;
  word_t                shreg;     // MSB drives sdi
  logic [BIT_CNT_W-1:0] bit_cnt;   // bits already sent
  logic [BIT_CNT_W-1:0] cnt;       // sck divider, reused for ldac length

  // ========================================
  // trigger sync and edge detect
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trig_s1 <= 1'b0;
      trig_s2 <= 1'b0;
      trig_d  <= 1'b0;
    end else begin
      trig_s1 <= trigger;
      trig_s2 <= trig_s1;
      trig_d  <= trig_s2;
    end
  end

  assign trig_edge = trig_s2 && !trig_d;  // one cycle per rising edge

  // ========================================
  // frame FSM
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      shreg    <= '0;  // keeps sdi low out of reset
      bit_cnt  <= '0;
      cnt      <= '0;
      sync_n   <= 1'b1;
      sck      <= 1'b0;
      ldac_n   <= 1'b1;
      underrun <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // edges during a frame are never looked at
          if (trig_edge) begin
            if (!fifo_empty) state <= ST_LOAD;
            else underrun <= 1'b1;  // sticky until reset
          end
        end
        ST_LOAD: begin
          shreg   <= fifo_rdata;  // popped this cycle
          bit_cnt <= '0;
          cnt     <= '0;
          sck     <= 1'b0;
          sync_n  <= 1'b0;  // frame starts
          state   <= ST_SHIFT;
        end
        ST_SHIFT: begin
          if (cnt == BIT_CNT_W'(SCK_HALF - 1)) begin
            cnt <= '0;
            sck <= ~sck;
            if (sck) begin
              // falling edge, move on to the next bit while sck is low
              shreg <= shreg << 1;
              if (bit_cnt == BIT_CNT_W'(WORD_W - 1)) begin
                sync_n <= 1'b1;  // after the last falling edge
                state  <= ST_GAP;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ST_GAP: begin
          cnt    <= '0;
          ldac_n <= 1'b0;
          state  <= ST_LDAC;
        end
        ST_LDAC: begin
          if (cnt == BIT_CNT_W'(LDAC_CYCLES - 1)) begin
            ldac_n <= 1'b1;  // DAC output updates here
            state  <= ST_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign fifo_rd = (state == ST_LOAD);  // single pop per frame
  assign sdi     = shreg[WORD_W-1];

  // ========================================
  // checks
  // ========================================
  a_sync_in_shift : assert property (@(posedge clk) disable iff (!rst_n)
    !sync_n |-> state == ST_SHIFT)
    else $error("sync_n low outside the shift window");

  // empty flag is owned by the FIFO
  a_rd_not_empty : assert property (@(posedge clk) disable iff (!rst_n)
    fifo_rd |-> !fifo_empty)
    else $error("serializer popped an empty FIFO");

endmodule : dac_serializer

`default_nettype wire

// File: dac_stream.f
+incdir+test
common/stream_pkg.sv
common/dac_frame_pkg.sv
rtl/word_fifo.sv
intake/host_word_intake.sv
dac/dac_serializer.sv
rtl/dac_stream_top.sv
test/tb_dac_stream.sv

// File: intake/host_word_intake.sv
// host word intake
// synchronizes the host request and runs the four-phase handshake
// new_word is the request and busy the acknowledge
// one FIFO write per handshake, held off while the FIFO is full

`default_nettype none

module host_word_intake (
  input  wire               clk,
  input  wire               rst_n,
  input  stream_pkg::word_t  host_word,
  input  wire               new_word,
  output logic              busy,
  input  wire               fifo_full,
  output logic              fifo_wr,
  output stream_pkg::word_t  fifo_wdata
);

  import stream_pkg::*;

  typedef enum logic [1:0] {
    IN_IDLE,   // wait for request
    IN_WRITE,  // write strobe cycle
    IN_ACK     // busy high until request drops
  } intake_state_t;

  intake_state_t state;

  logic req_s1;  // first sync stage, may go metastable
  logic req_s2;  // synchronized request

  // ========================================
  // request synchronizer
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_s1 <= 1'b0;
      req_s2 <= 1'b0;
    end else begin
      req_s1 <= new_word;
      req_s2 <= req_s1;
    end
  end

  // ========================================
  // handshake FSM
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IN_IDLE;
    end else begin
      case (state)
        IN_IDLE:  if (req_s2 && !fifo_full) state <= IN_WRITE;  // wait out back-pressure
        IN_WRITE: state <= IN_ACK;
        IN_ACK:   if (!req_s2) state <= IN_IDLE;  // host has let go
        default:  state <= IN_IDLE;
      endcase
    end
  end

  // capture the host word together with the write decision
  // host keeps it stable while new_word is high
  always_ff @(posedge clk) begin
    if (state == IN_IDLE && req_s2 && !fifo_full) begin
      fifo_wdata <= host_word;
    end
  end

  assign fifo_wr = (state == IN_WRITE);
  assign busy    = (state == IN_ACK);  // rises the cycle after the write

  // full flag comes from the FIFO a cycle after our last write
  a_no_wr_full : assert property (@(posedge clk) disable iff (!rst_n)
    fifo_wr |-> !fifo_full)
    else $error("intake wrote into a full FIFO");

endmodule : host_word_intake

`default_nettype wire

// File: rtl/dac_stream_top.sv
// host to DAC word streamer
// host words go through the intake into a word FIFO
// each trigger edge then sends one stored word out as a serial DAC frame

`default_nettype none

module dac_stream_top (
  input  wire              clk,
  input  wire              rst_n,
  input  stream_pkg::word_t host_word,  // held stable while new_word high
  input  wire              new_word,    // host request, async
  output logic             busy,        // acknowledge back to host
  input  wire              trigger,     // frame trigger, async
  output logic             sync_n,
  output logic             sck,
  output logic             sdi,
  output logic             ldac_n,
  output logic             underrun     // sticky
);

  import stream_pkg::*;

  // ========================================
  // FIFO side wires
  // ========================================
  logic  fifo_wr;     // write strobe from intake
  word_t fifo_wdata;
  logic  fifo_full;
  logic  fifo_rd;     // pop from serializer
  word_t fifo_rdata;  // head word
  logic  fifo_empty;

  // write side
  host_word_intake u_intake (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_word  (host_word),
    .new_word   (new_word),
    .busy       (busy),
    .fifo_full  (fifo_full),
    .fifo_wr    (fifo_wr),
    .fifo_wdata (fifo_wdata)
  );

  word_fifo u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_wr    (fifo_wr),
    .fifo_wdata (fifo_wdata),
    .fifo_rd    (fifo_rd),
    .fifo_rdata (fifo_rdata),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

  // read side, drives the DAC pins
  dac_serializer u_ser (
    .clk        (clk),
    .rst_n      (rst_n),
    .trigger    (trigger),
    .fifo_rdata (fifo_rdata),
    .fifo_empty (fifo_empty),
    .fifo_rd    (fifo_rd),
    .sync_n     (sync_n),
    .sck        (sck),
    .sdi        (sdi),
    .ldac_n     (ldac_n),
    .underrun   (underrun)
  );

endmodule : dac_stream_top

`default_nettype wire

// File: rtl/word_fifo.sv
// single clock word FIFO
// circular buffer of FIFO_DEPTH words with full and empty flags
// head word shows combinationally on fifo_rdata

`default_nettype none

module word_fifo (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               fifo_wr,
  input  stream_pkg::word_t  fifo_wdata,
  input  wire               fifo_rd,
  output stream_pkg::word_t  fifo_rdata,
  output logic              fifo_full,
  output logic              fifo_empty
);

  import stream_pkg::*;

  word_t            mem [FIFO_DEPTH];  // storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;  // occupancy, 0..FIFO_DEPTH
  logic             wr_en;
  logic             rd_en;

  // guard the array even though the neighbours should never overrun it
  assign wr_en = fifo_wr && !fifo_full;
  assign rd_en = fifo_rd && !fifo_empty;

  // ========================================
  // storage
  // ========================================
  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= fifo_wdata;
  end

  assign fifo_rdata = mem[rd_ptr];  // valid while not empty

  // pointers and count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // flags straight off the count
  assign fifo_full  = (count == (PTR_W+1)'(FIFO_DEPTH));
  assign fifo_empty = (count == '0);

  // ========================================
  // checks on the neighbours
  // ========================================
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    fifo_wr |-> !fifo_full)
    else $error("write while FIFO full");

  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    fifo_rd |-> !fifo_empty)
    else $error("read while FIFO empty");

endmodule : word_fifo

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the DAC streamer testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_dac_stream -f dac_stream.f -Mdir "$OBJ" -o sim_dac_stream
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/sim_dac_stream" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "result: fail"
  exit 1
fi

echo "result: pass"
exit 0

// File: test/tb_tasks.svh
// directed tests for the DAC streamer
// check helpers, host handshake and trigger drivers, one task per test

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ========================================
// checks and test bookkeeping
// ========================================
task automatic compare_word(input string what, input word_t expected,
                            input word_t actual);
  check_count++;
  assert (actual === expected) else begin
    $display("MISMATCH %s %s: expected %h actual %h", cur_test, what, expected, actual);
    err_count++;
  end
endtask

task automatic compare_int(input string what, input int expected, input int actual);
  check_count++;
  assert (actual == expected) else begin
    $display("MISMATCH %s %s: expected %0d actual %0d", cur_test, what, expected, actual);
    err_count++;
  end
endtask

task automatic expect_true(input bit cond, input string msg);
  check_count++;
  assert (cond) else begin
    $display("ERROR %s: %s", cur_test, msg);
    err_count++;
  end
endtask

task automatic start_test(input string name);
  cur_test    = name;
  errs_before = err_count;
  frame_base  = frames.size();  // older frames belong to earlier tests
  test_count++;
endtask

task automatic report_test();
  if (err_count == errs_before) $display("test %s: ok", cur_test);
  else $display("test %s: %0d errors", cur_test, err_count - errs_before);
endtask

// ========================================
// drivers
// ========================================
task automatic next_cycle();
  @(posedge clk);
  #2;  // inputs move just after the edge
endtask

task automatic wait_busy(input logic level, input int limit, output bit seen);
  seen = 1'b0;
  for (int i = 0; i < limit && !seen; i++) begin
    next_cycle();
    if (busy == level) seen = 1'b1;
  end
endtask

// full four-phase handshake
task automatic send_word(input word_t w);
  bit seen;
  host_word = w;
  new_word  = 1'b1;
  wait_busy(1'b1, HS_LIMIT, seen);
  expect_true(seen, "busy never rose for the host request");
  new_word = 1'b0;
  wait_busy(1'b0, HS_LIMIT, seen);
  expect_true(seen, "busy stayed high after the request dropped");
endtask

task automatic pulse_trigger();
  trigger = 1'b1;
  repeat (3) next_cycle();  // wide enough for the synchronizer
  trigger = 1'b0;
endtask

task automatic wait_ldac(input int start_count);
  bit done;
  done = 1'b0;
  for (int i = 0; i < FRAME_LIMIT && !done; i++) begin
    next_cycle();
    if (ldac_pulses > start_count && ldac_n) done = 1'b1;
  end
  expect_true(done, "no ldac_n pulse followed the trigger");
endtask

task automatic run_frame();
  int start;
  start = ldac_pulses;
  pulse_trigger();
  wait_ldac(start);
endtask

// frames of this test against the words sent, in order
task automatic check_frames(input word_t expected[$]);
  compare_int("frame count", expected.size(), frames.size() - frame_base);
  foreach (expected[i]) begin
    if (frame_base + i < frames.size()) begin
      compare_int("frame bits", WORD_W, frame_bits[frame_base + i]);
      compare_word("frame data", expected[i], frames[frame_base + i]);
    end
  end
endtask

// ========================================
// tests
// ========================================
task automatic check_reset_values();
  start_test("reset_state");
  compare_int("busy", 0, int'(busy));
  compare_int("sync_n", 1, int'(sync_n));
  compare_int("sck", 0, int'(sck));
  compare_int("sdi", 0, int'(sdi));
  compare_int("ldac_n", 1, int'(ldac_n));
  compare_int("underrun", 0, int'(underrun));
  report_test();
endtask

task automatic single_word_frame();
  word_t sent[$];
  word_t w;
  int    start;
  start_test("single_word");
  w = next_word();
  sent.push_back(w);
  send_word(w);
  start = ldac_pulses;
  run_frame();
  check_frames(sent);
  compare_int("ldac pulses", 1, ldac_pulses - start);
  report_test();
endtask

task automatic word_ordering();
  word_t sent[$];
  word_t w;
  start_test("ordering");
  repeat (8) begin
    w = next_word();
    sent.push_back(w);
    send_word(w);
  end
  repeat (8) run_frame();
  check_frames(sent);
  report_test();
endtask

task automatic full_fifo_backpressure();
  word_t sent[$];
  word_t w;
  bit    seen;
  int    start;
  start_test("back_pressure");
  repeat (FIFO_DEPTH) begin
    w = next_word();
    sent.push_back(w);
    send_word(w);
  end
  w = next_word();  // one more than fits
  sent.push_back(w);
  host_word = w;
  new_word  = 1'b1;
  wait_busy(1'b1, 50, seen);
  expect_true(!seen, "busy rose while the FIFO was full");
  start = ldac_pulses;
  pulse_trigger();  // frees one entry
  wait_busy(1'b1, HS_LIMIT, seen);
  expect_true(seen, "handshake did not complete after a pop");
  new_word = 1'b0;
  wait_busy(1'b0, HS_LIMIT, seen);
  expect_true(seen, "busy stayed high after the request dropped");
  wait_ldac(start);
  repeat (FIFO_DEPTH) run_frame();
  check_frames(sent);
  report_test();
endtask

task automatic empty_fifo_underrun();
  bit went_low;
  start_test("underrun");
  went_low = 1'b0;
  compare_int("underrun before trigger", 0, int'(underrun));  // no empty pop so far
  pulse_trigger();
  for (int i = 0; i < 100; i++) begin
    next_cycle();
    if (!sync_n) went_low = 1'b1;
  end
  expect_true(!went_low, "sync_n fell although the FIFO was empty");
  compare_int("underrun", 1, int'(underrun));
  compare_int("frame count", 0, frames.size() - frame_base);
  report_test();
endtask

`endif

// File: test/tb_dac_stream.sv
// testbench for the host to DAC word streamer
// drives the host handshake and the trigger, captures the serial frames
// and compares them with the words that were sent

`default_nettype none

module tb_dac_stream;
  timeunit 1ns;
  timeprecision 1ps;

  import stream_pkg::*;

  localparam int HS_LIMIT    = 20;   // cycles to wait for a busy edge
  localparam int FRAME_LIMIT = 200;  // one frame incl. trigger sync, ~90 cycles
  // about 40 frames of 90 cycles plus the handshakes, with a wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic  clk = 1'b0;
  logic  rst_n;
  word_t host_word;
  logic  new_word;
  logic  trigger;
  logic  busy;
  logic  sync_n;
  logic  sck;
  logic  sdi;
  logic  ldac_n;
  logic  underrun;

  // ========================================
  // bookkeeping
  // ========================================
  logic [31:0] lcg_state = 32'h3f67_5f63;
  word_t       frames[$];      // completed frames, oldest first
  int          frame_bits[$];  // bit count per frame
  word_t       cap_word = '0;
  int          cap_bits = 0;
  logic        sck_q = 1'b0;   // sck and sdi at the previous falling clk edge
  logic        sdi_q = 1'b0;
  int          ldac_pulses = 0;
  int          cycle_count = 0;
  int          frame_base;     // first frame of the running test
  int          err_count = 0;
  int          check_count = 0;
  int          test_count = 0;
  int          errs_before;
  string       cur_test;

  dac_stream_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .host_word (host_word),
    .new_word  (new_word),
    .busy      (busy),
    .trigger   (trigger),
    .sync_n    (sync_n),
    .sck       (sck),
    .sdi       (sdi),
    .ldac_n    (ldac_n),
    .underrun  (underrun)
  );

  always #10 clk = ~clk;  // 20 ns period

  // DAC side model, looks mid cycle and picks up each rising sck
  always @(negedge clk) begin
    if (sync_n === 1'b1) begin
      if (cap_bits != 0) begin  // end of frame
        frames.push_back(cap_word);
        frame_bits.push_back(cap_bits);
      end
      cap_word = '0;
      cap_bits = 0;
    end else if (sck === 1'b1 && sck_q === 1'b0) begin
      check_count++;
      assert (sdi === sdi_q) else begin  // DAC samples on this edge
        $display("ERROR %s: sdi moved across a rising sck edge", cur_test);
        err_count++;
      end
      cap_word = {cap_word[WORD_W-2:0], sdi};  // MSB first
      cap_bits++;
    end
    sck_q = sck;
    sdi_q = sdi;
  end

  always @(negedge ldac_n) ldac_pulses++;

  // run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // 32 bit LCG, upper bits make the word
  function automatic word_t next_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:12];
  endfunction

  `include "tb_tasks.svh"

  initial begin
    rst_n     = 1'b0;
    host_word = '0;
    new_word  = 1'b0;
    trigger   = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    next_cycle();
    check_reset_values();
    single_word_frame();
    word_ordering();
    full_fifo_backpressure();
    empty_fifo_underrun();
    $display("tests: %0d  checks: %0d  errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tb_dac_stream

`default_nettype wire
